// File: list.f
+incdir+logic
logic/th_pkg.sv
logic/th_wb_regs.sv
logic/th_pattern_gen.sv
logic/th_engine.sv
logic/th_mem.sv
logic/th_status.sv
logic/th_top.sv
dv/th_tb.sv

// File: Makefile
TOP := th_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: dv/th_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "th_config.svh"

module th_tb
  import th_pkg::*;
();

  localparam int MEM_WORDS   = 2 ** `TH_MEM_AW;
  localparam int ACK_TIMEOUT = 20;
  localparam int POLL_LIMIT  = 2000;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic [1:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;

  integer      seed_var;
  logic [15:0] ref_mem [MEM_WORDS]; // reference copy of the memory under test
  logic [15:0] exp_err;
  logic [15:0] exp_first;
  logic        exp_fail;
  logic [15:0] got_flags;
  logic [15:0] got_err;
  logic [15:0] got_first;

  th_top u_dut (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_sel_i (wb_sel_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  ////////////////////
  // bus and checking
  ////////////////////

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic bus_access(input logic we, input logic [20:0] addr, input logic [15:0] data,
                            input logic [1:0] sel, output logic [15:0] rdata);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= {10'd0, addr, 1'b0};
    wb_sel_i <= sel;
    wb_dat_i <= data;
    @(negedge wb_clk_i);
    while (wb_ack_o !== 1'b1) begin
      if (waited == ACK_TIMEOUT) begin
        $display("timeout: no ack for an access to word address %0d", addr);
        stop_on_failure();
      end
      waited++;
      @(negedge wb_clk_i);
    end
    rdata = wb_dat_o; // read data is stable while ack is high
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [20:0] addr, input logic [15:0] data, input logic [1:0] sel);
    logic [15:0] unused;
    bus_access(1'b1, addr, data, sel, unused);
  endtask

  task automatic wb_read(input logic [20:0] addr, output logic [15:0] data);
    bus_access(1'b0, addr, 16'd0, 2'b11, data);
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [15:0] pattern_word(input th_pattern_e pat, input logic [15:0] seed,
                                               input int idx);
    logic [15:0] state;
    logic        fb;
    state = (seed == 16'd0) ? 16'd1 : seed;
    case (pat)
      PAT_CONST: return seed;
      PAT_INCR:  return seed + idx[15:0];
      PAT_WALK1: return 16'd1 << (idx % 16);
      default: begin
        for (int k = 0; k < idx; k++) begin
          fb    = state[15] ^ state[13] ^ state[12] ^ state[10]; // taps 16 14 13 11
          state = {state[14:0], fb};
        end
        return state;
      end
    endcase
  endfunction

  task automatic predict_run(input th_pattern_e pat, input logic [15:0] start,
                             input logic [15:0] count, input logic [15:0] seed,
                             input logic inj_en, input logic [15:0] inj_idx);
    int          addr;
    logic [15:0] word;
    exp_err   = 16'd0;
    exp_first = 16'd0;
    exp_fail  = 1'b0;
    for (int i = 0; i < int'(count); i++) begin
      addr = (int'(start) + i) % MEM_WORDS;
      word = pattern_word(pat, seed, i);
      if (inj_en && (i[15:0] == inj_idx)) begin
        word[0] = ~word[0];
      end
      ref_mem[addr] = word;
    end
    for (int i = 0; i < int'(count); i++) begin
      addr = (int'(start) + i) % MEM_WORDS;
      if (ref_mem[addr] !== pattern_word(pat, seed, i)) begin
        if (!exp_fail) begin
          exp_first = addr[15:0];
        end
        exp_fail = 1'b1;
        if (exp_err != 16'hffff) begin
          exp_err++;
        end
      end
    end
  endtask

  task automatic run_test(input th_pattern_e pat, input logic [15:0] start,
                          input logic [15:0] count, input logic [15:0] seed,
                          input logic inj_en, input logic [15:0] inj_idx);
    logic [15:0] ctrl0;
    int          polls;
    ctrl0 = {12'd0, inj_en, pat, 1'b0};
    polls = 0;
    predict_run(pat, start, count, seed, inj_en, inj_idx);
    wb_write(`TH_REG_CTRL_1, start, 2'b11);
    wb_write(`TH_REG_CTRL_2, count, 2'b11);
    wb_write(`TH_REG_CTRL_3, seed, 2'b11);
    wb_write(`TH_REG_CTRL_4, inj_idx, 2'b11);
    wb_write(`TH_REG_CTRL_0, ctrl0, 2'b11); // start goes low first so the engine sees a rising edge
    wb_write(`TH_REG_CTRL_0, ctrl0 | 16'h0001, 2'b11);
    got_flags = 16'd0;
    while (got_flags[1] !== 1'b1) begin
      if (polls == POLL_LIMIT) begin
        $display("timeout: done never set for a run of %0d words", count);
        stop_on_failure();
      end
      polls++;
      wb_read(`TH_REG_STAT_FLAGS, got_flags);
      if (got_flags[1] !== 1'b1) begin
        check("busy while the run is going", {15'd0, got_flags[0]}, 16'd1);
      end
    end
    wb_read(`TH_REG_STAT_ERRCNT, got_err);
    wb_read(`TH_REG_STAT_FIRST, got_first);
    check("status flags", got_flags, {13'd0, exp_fail, 1'b1, 1'b0});
    check("error count", got_err, exp_err);
    check("first failing address", got_first, exp_first);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reg_access();
    logic [15:0] shadow [5];
    logic [15:0] wdata;
    logic [15:0] got;
    logic [20:0] addr;
    wb_read(`TH_REG_STAT_FLAGS, got);
    check("flags after reset", got, 16'd0);
    wb_read(`TH_REG_STAT_ERRCNT, got);
    check("error count after reset", got, 16'd0);
    for (int r = 0; r < 5; r++) begin
      wb_read(`TH_REG_CTRL_0 + 21'(r), got);
      check("control register after reset", got, 16'd0);
      shadow[r] = 16'd0;
    end
    for (int r = 1; r < 5; r++) begin
      addr = `TH_REG_CTRL_0 + 21'(r);
      for (int s = 0; s < 4; s++) begin
        wdata = 16'($random(seed_var));
        wb_write(addr, wdata, s[1:0]);
        if (s[0]) begin
          shadow[r][7:0] = wdata[7:0];
        end
        if (s[1]) begin
          shadow[r][15:8] = wdata[15:8];
        end
        wb_read(addr, got);
        check("control register byte merge", got, shadow[r]);
      end
    end
  endtask

  task automatic test_patterns();
    logic [15:0] count;
    for (int p = 0; p < 4; p++) begin
      count = 16'd1 + 16'($unsigned($random(seed_var)) % 300);
      run_test(th_pattern_e'(p), 16'($random(seed_var)), count, 16'($random(seed_var)),
               1'b0, 16'd0);
      check("flags of a clean run", got_flags, 16'h0002);
      check("error count of a clean run", got_err, 16'd0);
    end
    run_test(PAT_LFSR, 16'h0123, 16'd64, 16'd0, 1'b0, 16'd0); // zero seed falls back to 1
  endtask

  task automatic test_inject_wrap();
    logic [15:0] start;
    logic [15:0] idx;
    for (int p = 0; p < 4; p++) begin
      start = 16'h8000 * 16'(p & 1) + 16'd1016 + 16'($unsigned($random(seed_var)) % 8);
      idx   = 16'd20 + 16'($unsigned($random(seed_var)) % 10); // lands past the top of memory
      run_test(th_pattern_e'(p), start, 16'd40, 16'($random(seed_var)), 1'b1, idx);
      check("flags with one injected error", got_flags, 16'h0006);
      check("error count with one injected error", got_err, 16'd1);
      check("wrapped failing address", got_first,
            16'((int'(start) + int'(idx)) % MEM_WORDS));
    end
  endtask

  task automatic test_no_error();
    run_test(PAT_INCR, 16'd200, 16'd32, 16'h00f0, 1'b1, 16'd32);
    check("error count, inject index at count", got_err, 16'd0);
    run_test(PAT_WALK1, 16'd1000, 16'd50, 16'h0000, 1'b1, 16'hffff);
    check("error count, inject index past count", got_err, 16'd0);
    run_test(PAT_CONST, 16'd5, 16'd0, 16'h1234, 1'b1, 16'd0);
    check("flags of an empty run", got_flags, 16'h0002);
    check("error count of an empty run", got_err, 16'd0);
  endtask

  task automatic test_restart_unknown();
    logic [15:0] got;
    run_test(PAT_LFSR, 16'd700, 16'd100, 16'hbeef, 1'b1, 16'd50);
    check("flags before restart", got_flags, 16'h0006);
    run_test(PAT_LFSR, 16'd700, 16'd100, 16'hbeef, 1'b0, 16'd50);
    check("flags after restart", got_flags, 16'h0002);
    check("error count after restart", got_err, 16'd0);
    wb_read(21'd5, got);
    check("unknown address 5", got, 16'd0);
    wb_read(21'd100, got);
    check("unknown address 100", got, 16'd0);
    wb_read(21'h1fffff, got);
    check("unknown top address", got, 16'd0);
  endtask

  initial begin
    seed_var = 10588;
    wb_rst_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_sel_i = 2'b00;
    wb_adr_i = 32'd0;
    wb_dat_i = 16'd0;
    repeat (2) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    @(negedge wb_clk_i);
    check("ack after reset", {15'd0, wb_ack_o}, 16'd0);
    test_reg_access();
    test_patterns();
    test_inject_wrap();
    test_no_error();
    test_restart_unknown();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/th_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "th_config.svh"

module th_top
  import th_pkg::*;
(
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  input  wire         wb_we_i,
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire  [1:0]  wb_sel_i,
  input  wire  [31:0] wb_adr_i,
  input  wire  [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o
);

  th_ctrl_t              ctrl;
  th_result_t            result;
  logic [20:0]           status_addr;
  logic [15:0]           status_word;
  logic                  gen_restart;
  logic                  gen_advance;
  logic [`TH_DW-1:0]     gen_data;
  logic                  mem_en;
  logic                  mem_we;
  logic [`TH_MEM_AW-1:0] mem_addr;
  logic [`TH_DW-1:0]     mem_wdata;
  logic [`TH_DW-1:0]     mem_rdata;

  ////////////////////
  // host side
  ////////////////////

  th_wb_regs u_regs (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .status_addr_o (status_addr),
    .status_i      (status_word),
    .ctrl_o        (ctrl)
  );

  th_status u_status (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .result_i      (result),
    .status_addr_i (status_addr),
    .status_o      (status_word)
  );

  ////////////////////
  // test datapath
  ////////////////////

  th_engine u_engine (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .ctrl_i        (ctrl),
    .gen_restart_o (gen_restart),
    .gen_advance_o (gen_advance),
    .gen_data_i    (gen_data),
    .mem_en_o      (mem_en),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_rdata_i   (mem_rdata),
    .result_o      (result)
  );

  th_pattern_gen u_gen (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .restart_i (gen_restart),
    .advance_i (gen_advance),
    .pattern_i (ctrl.pattern), // taken at each restart
    .seed_i    (ctrl.seed),
    .data_o    (gen_data)
  );

  th_mem u_mem (
    .wb_clk_i (wb_clk_i),
    .en_i     (mem_en),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (mem_rdata)
  );

endmodule

`default_nettype wire

// File: logic/th_status.sv
`timescale 1ns/1ps
`default_nettype none
`include "th_config.svh"

module th_status
  import th_pkg::*;
(
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,
  input  wire  th_result_t   result_i,
  input  wire  [20:0]        status_addr_i,
  output logic [15:0]        status_o
);

  logic                  busy_q;
  logic                  done_q;
  logic                  fail_q;
  logic [15:0]           err_cnt_q;
  logic [`TH_MEM_AW-1:0] first_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      fail_q    <= 1'b0;
      err_cnt_q <= '0;
      first_q   <= '0;
    end else if (result_i.run_start) begin // a new run wipes the old result
      busy_q    <= 1'b1;
      done_q    <= 1'b0;
      fail_q    <= 1'b0;
      err_cnt_q <= '0;
      first_q   <= '0;
    end else begin
      if (result_i.cmp_valid && result_i.mismatch) begin
        fail_q <= 1'b1;
        if (err_cnt_q != 16'hffff) begin
          err_cnt_q <= err_cnt_q + 16'd1;
        end
        if (!fail_q) begin
          first_q <= result_i.cmp_addr;
        end
      end
      if (result_i.run_done) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (status_addr_i)
      `TH_REG_STAT_FLAGS:  status_o = {13'd0, fail_q, done_q, busy_q};
      `TH_REG_STAT_ERRCNT: status_o = err_cnt_q;
      `TH_REG_STAT_FIRST:  status_o = {{(16-`TH_MEM_AW){1'b0}}, first_q};
      default:             status_o = '0;
    endcase
  end

  a_busy_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(busy_q && done_q));

  // the engine only ends a run that the status block saw start
  a_done_after_start: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    result_i.run_done |-> busy_q);

endmodule

`default_nettype wire

// File: logic/th_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "th_config.svh"

module th_mem (
  input  wire                   wb_clk_i,
  input  wire                   en_i,
  input  wire                   we_i,
  input  wire  [`TH_MEM_AW-1:0] addr_i,
  input  wire  [`TH_DW-1:0]     wdata_i,
  output logic [`TH_DW-1:0]     rdata_o
);

  localparam int DEPTH = 2 ** `TH_MEM_AW;

  logic [`TH_DW-1:0] mem_q [DEPTH];

  always_ff @(posedge wb_clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i]; // valid the cycle after the read
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/th_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "th_config.svh"

module th_engine
  import th_pkg::*;
(
  input  wire                    wb_clk_i,
  input  wire                    wb_rst_i,
  input  wire  th_ctrl_t         ctrl_i,
  output logic                   gen_restart_o,
  output logic                   gen_advance_o,
  input  wire  [`TH_DW-1:0]      gen_data_i,
  output logic                   mem_en_o,
  output logic                   mem_we_o,
  output logic [`TH_MEM_AW-1:0]  mem_addr_o,
  output logic [`TH_DW-1:0]      mem_wdata_o,
  input  wire  [`TH_DW-1:0]      mem_rdata_i,
  output th_result_t             result_o
);

  th_state_e             state_q;
  logic                  start_q;
  logic                  start_accept;
  logic [`TH_MEM_AW-1:0] base_q;
  logic [`TH_MEM_AW-1:0] addr_q;
  logic [15:0]           count_q;
  logic [15:0]           idx_q;
  logic                  inject_en_q;
  logic [15:0]           inject_idx_q;
  logic                  last_word;
  logic                  flip_bit;
  logic                  run_start_q;
  logic                  run_done_q;
  logic                  cmp_pending_q;
  logic [`TH_DW-1:0]     exp_q;
  logic [`TH_MEM_AW-1:0] cmp_addr_q;

  assign start_accept = ctrl_i.start & ~start_q & ((state_q == IDLE) | (state_q == DONE));
  assign last_word    = (idx_q == count_q - 16'd1);
  assign flip_bit     = inject_en_q & (idx_q == inject_idx_q); // never hits when idx >= count

  ////////////////////
  // sequencing
  ////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q       <= IDLE;
      start_q       <= 1'b0;
      base_q        <= '0;
      addr_q        <= '0;
      count_q       <= '0;
      idx_q         <= '0;
      inject_en_q   <= 1'b0;
      inject_idx_q  <= '0;
      run_start_q   <= 1'b0;
      run_done_q    <= 1'b0;
      cmp_pending_q <= 1'b0;
    end else begin
      start_q       <= ctrl_i.start;
      run_start_q   <= start_accept;
      run_done_q    <= (state_q == DRAIN);
      cmp_pending_q <= (state_q == READ);
      case (state_q)
        IDLE, DONE: begin
          if (start_accept) begin
            base_q       <= ctrl_i.start_addr[`TH_MEM_AW-1:0];
            addr_q       <= ctrl_i.start_addr[`TH_MEM_AW-1:0];
            count_q      <= ctrl_i.count;
            inject_en_q  <= ctrl_i.inject_en;
            inject_idx_q <= ctrl_i.inject_idx;
            idx_q        <= '0;
            state_q      <= (ctrl_i.count == 16'd0) ? DRAIN : WRITE;
          end
        end
        WRITE: begin
          addr_q <= addr_q + 1'b1; // wraps at the memory depth
          idx_q  <= idx_q + 16'd1;
          if (last_word) begin
            addr_q  <= base_q;
            idx_q   <= '0;
            state_q <= READ;
          end
        end
        READ: begin
          addr_q <= addr_q + 1'b1;
          idx_q  <= idx_q + 16'd1;
          if (last_word) begin
            state_q <= DRAIN;
          end
        end
        DRAIN:   state_q <= DONE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // expected word lines up with the one cycle memory read
  always_ff @(posedge wb_clk_i) begin
    if (state_q == READ) begin
      exp_q      <= gen_data_i;
      cmp_addr_q <= addr_q;
    end
  end

  assign gen_restart_o = start_accept | ((state_q == WRITE) & last_word);
  assign gen_advance_o = (state_q == WRITE) | (state_q == READ);
  assign mem_en_o      = (state_q == WRITE) | (state_q == READ);
  assign mem_we_o      = (state_q == WRITE);
  assign mem_addr_o    = addr_q;
  assign mem_wdata_o   = gen_data_i ^ {{(`TH_DW-1){1'b0}}, flip_bit};

  always_comb begin
    result_o.run_start = run_start_q;
    result_o.cmp_valid = cmp_pending_q;
    result_o.mismatch  = cmp_pending_q & (mem_rdata_i != exp_q);
    result_o.cmp_addr  = cmp_addr_q;
    result_o.run_done  = run_done_q;
  end

  // a write never overlaps a compare of the read pass
  a_we_in_write: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    mem_we_o |-> (state_q == WRITE) && !result_o.cmp_valid);

endmodule

`default_nettype wire

// File: logic/th_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "th_config.svh"

module th_pattern_gen
  import th_pkg::*;
(
  input  wire                  wb_clk_i,
  input  wire                  wb_rst_i,
  input  wire                  restart_i,
  input  wire                  advance_i,
  input  wire  th_pattern_e    pattern_i,
  input  wire  [`TH_DW-1:0]    seed_i,
  output logic [`TH_DW-1:0]    data_o
);

  th_pattern_e       pattern_q;
  logic [`TH_DW-1:0] seed_q;
  logic [15:0]       index_q;
  logic [`TH_DW-1:0] walk_q;
  logic [15:0]       lfsr_q;
  logic              lfsr_fb;

  // taps 16, 14, 13, 11, shifting toward the msb
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pattern_q <= PAT_CONST;
      seed_q    <= '0;
      index_q   <= '0;
      walk_q    <= `TH_DW'd1;
      lfsr_q    <= 16'd1;
    end else if (restart_i) begin // restart wins over advance
      pattern_q <= pattern_i;
      seed_q    <= seed_i;
      index_q   <= '0;
      walk_q    <= `TH_DW'd1;
      lfsr_q    <= (seed_i == '0) ? 16'd1 : seed_i; // all zero state would lock up
    end else if (advance_i) begin
      index_q <= index_q + 16'd1;
      walk_q  <= {walk_q[`TH_DW-2:0], walk_q[`TH_DW-1]};
      lfsr_q  <= {lfsr_q[14:0], lfsr_fb};
    end
  end

  always_comb begin
    case (pattern_q)
      PAT_CONST: data_o = seed_q;
      PAT_INCR:  data_o = seed_q + index_q;
      PAT_WALK1: data_o = walk_q;
      PAT_LFSR:  data_o = lfsr_q;
      default:   data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/th_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "th_config.svh"

module th_wb_regs
  import th_pkg::*;
(
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  input  wire         wb_we_i,
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire  [1:0]  wb_sel_i,
  input  wire  [31:0] wb_adr_i,
  input  wire  [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic [20:0] status_addr_o,
  input  wire  [15:0] status_i,
  output th_ctrl_t    ctrl_o
);

  localparam int NUM_CTRL = 5;

  logic [NUM_CTRL-1:0][15:0] ctrl_q;
  logic [20:0]               rd_addr_q; // address of the last access, selects read data
  logic [20:0]               word_addr;
  logic                      access;
  logic [NUM_CTRL-1:0]       wr_hit;
  logic [NUM_CTRL-1:0]       rd_hit;

  function automatic logic [NUM_CTRL-1:0] ctrl_decode(input logic [20:0] addr);
    logic [NUM_CTRL-1:0] hit;
    hit[0] = (addr == `TH_REG_CTRL_0);
    hit[1] = (addr == `TH_REG_CTRL_1);
    hit[2] = (addr == `TH_REG_CTRL_2);
    hit[3] = (addr == `TH_REG_CTRL_3);
    hit[4] = (addr == `TH_REG_CTRL_4);
    return hit;
  endfunction

  assign word_addr = wb_adr_i[21:1];
  assign access    = wb_cyc_i & wb_stb_i & ~wb_ack_o; // one ack per strobe
  assign wr_hit    = ctrl_decode(word_addr);
  assign rd_hit    = ctrl_decode(rd_addr_q);

  ////////////////////
  // register writes
  ////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o  <= 1'b0;
      rd_addr_q <= '0;
      ctrl_q    <= '0;
    end else begin
      wb_ack_o <= access;
      if (access) begin
        rd_addr_q <= word_addr;
      end
      for (int r = 0; r < NUM_CTRL; r++) begin
        for (int b = 0; b < 2; b++) begin
          if (access && wb_we_i && wr_hit[r] && wb_sel_i[b]) begin
            ctrl_q[r][8*b +: 8] <= wb_dat_i[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////
  // read data
  ////////////////////

  always_comb begin
    wb_dat_o = status_i; // anything outside the control words goes to the status block
    for (int r = 0; r < NUM_CTRL; r++) begin
      if (rd_hit[r]) begin
        wb_dat_o = ctrl_q[r];
      end
    end
  end

  assign status_addr_o = rd_addr_q;
  assign ctrl_o        = th_ctrl_t'(ctrl_q);

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

// File: logic/th_pkg.sv
`default_nettype none
`include "th_config.svh"

package th_pkg;

  typedef enum logic [1:0] {
    PAT_CONST = 2'd0,
    PAT_INCR  = 2'd1,
    PAT_WALK1 = 2'd2,
    PAT_LFSR  = 2'd3
  } th_pattern_e;

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    WRITE = 3'd1,
    READ  = 3'd2,
    DRAIN = 3'd3, // last compare still in flight
    DONE  = 3'd4
  } th_state_e;

  // five 16 bit control registers, CTRL_0 in the low word
  typedef struct packed {
    logic [15:0] inject_idx;
    logic [15:0] seed;
    logic [15:0] count;
    logic [15:0] start_addr;
    logic [11:0] reserved;
    logic        inject_en;
    th_pattern_e pattern;
    logic        start;
  } th_ctrl_t;

  typedef struct packed {
    logic                  run_start;
    logic                  cmp_valid;
    logic                  mismatch;
    logic [`TH_MEM_AW-1:0] cmp_addr;
    logic                  run_done;
  } th_result_t;

endpackage

`default_nettype wire

// File: logic/th_config.svh
`ifndef TH_CONFIG_SVH
`define TH_CONFIG_SVH

////////////////////
// register map, word addresses taken from wb_adr_i[21:1]
////////////////////

`define TH_REG_CTRL_0      21'd0
`define TH_REG_CTRL_1      21'd1
`define TH_REG_CTRL_2      21'd2
`define TH_REG_CTRL_3      21'd3
`define TH_REG_CTRL_4      21'd4

`define TH_REG_STAT_FLAGS  21'd16
`define TH_REG_STAT_ERRCNT 21'd17
`define TH_REG_STAT_FIRST  21'd18

////////////////////
// memory geometry
////////////////////

`define TH_MEM_AW 10 // 1024 words
`define TH_DW     16

`endif
